// ==== issue_queue_top.f ====
+incdir+tb
rtl/iq_pkg.sv
rtl/csr_pkg.sv
rtl/iq_age_if.sv
rtl/iq_ctrl_if.sv
rtl/age_deq_policy.sv
rtl/iq_entry_array.sv
rtl/iq_csr.sv
rtl/issue_queue_top.sv
tb/issue_queue_tb.sv

// ==== rtl/age_deq_policy.sv ====
module age_deq_policy (
    input logic      clock,
    input logic      reset_n,
    iq_age_if.policy age
);

    // age_q[i][j] set means entry i older than entry j
    logic [iq_pkg::iq_depth-1:0][iq_pkg::iq_depth-1:0] age_q;
    logic [iq_pkg::iq_depth-1:0]                       older_ready;

    // ----------------------------------------
    // oldest ready pick
    // ----------------------------------------
    always_comb begin
        older_ready = '0;
        for (int i = 0; i < iq_pkg::iq_depth; i++) begin
            for (int j = 0; j < iq_pkg::iq_depth; j++) begin
                // diagonal stays 0 so j == i never blocks
                if (age_q[j][i] && age.ready_to_go[j]) begin
                    older_ready[i] = 1'b1;
                end
            end
        end
    end

    // age order is total over valid slots, so at most one bit survives
    assign age.oldest_oh    = age.ready_to_go & ~older_ready;
    assign age.oldest_found = |age.oldest_oh;

    // ----------------------------------------
    // matrix update
    // ----------------------------------------
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            age_q <= '0;
        end else begin
            for (int k = 0; k < iq_pkg::iq_depth; k++) begin
                if (age.wren_oh[k]) begin
                    for (int j = 0; j < iq_pkg::iq_depth; j++) begin
                        age_q[j][k] <= age.valid[j];    // every live entry is older
                        age_q[k][j] <= 1'b0;            // new slot older than nobody
                    end
                end
            end
            // clear last so a freed slot wins over a same cycle write
            for (int k = 0; k < iq_pkg::iq_depth; k++) begin
                if (age.clear_oh[k]) begin
                    for (int j = 0; j < iq_pkg::iq_depth; j++) begin
                        age_q[k][j] <= 1'b0;    // row
                        age_q[j][k] <= 1'b0;    // column
                    end
                end
            end
        end
    end

endmodule

// ==== rtl/csr_pkg.sv ====
package csr_pkg;

    // axi4-lite bus widths
    localparam int axil_addr_width = 4;
    localparam int axil_data_width = 32;

    // ----------------------------------------
    // register map
    // ----------------------------------------
    localparam logic [axil_addr_width-1:0] ctrl_addr   = 4'h0;
    localparam logic [axil_addr_width-1:0] status_addr = 4'h4;   // read only
    localparam logic [axil_addr_width-1:0] count_addr  = 4'h8;   // write clears

    // field positions
    localparam int ctrl_enable_bit  = 0;
    localparam int ctrl_flush_bit   = 1;    // self clearing
    localparam int status_full_bit  = 4;    // occupancy in 3:0
    localparam int status_empty_bit = 5;

    // response codes
    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

endpackage

// ==== rtl/iq_age_if.sv ====
interface iq_age_if #(
    parameter int depth = 8
);

    // entry array side
    logic [depth-1:0] ready_to_go;  // valid and both sources ready
    logic [depth-1:0] valid;
    logic [depth-1:0] wren_oh;      // slot written this cycle
    logic [depth-1:0] clear_oh;     // slots freed this cycle

    // age policy side
    logic             oldest_found;
    logic [depth-1:0] oldest_oh;

    modport array (
        output ready_to_go, valid, wren_oh, clear_oh,
        input  oldest_found, oldest_oh
    );

    modport policy (
        input  ready_to_go, valid, wren_oh, clear_oh,
        output oldest_found, oldest_oh
    );

endinterface

// ==== rtl/iq_csr.sv ====
module iq_csr (
    input  logic                                   clock,
    input  logic                                   reset_n,
    input  logic [csr_pkg::axil_addr_width-1:0]    awaddr,
    input  logic                                   awvalid,
    output logic                                   awready,
    input  logic [csr_pkg::axil_data_width-1:0]    wdata,
    input  logic [csr_pkg::axil_data_width/8-1:0]  wstrb,
    input  logic                                   wvalid,
    output logic                                   wready,
    output logic [1:0]                             bresp,
    output logic                                   bvalid,
    input  logic                                   bready,
    input  logic [csr_pkg::axil_addr_width-1:0]    araddr,
    input  logic                                   arvalid,
    output logic                                   arready,
    output logic [csr_pkg::axil_data_width-1:0]    rdata,
    output logic [1:0]                             rresp,
    output logic                                   rvalid,
    input  logic                                   rready,
    iq_ctrl_if.csr                                 ctrl
);

    logic                                wr_accept;     // aw and w ready pulse
    logic                                rd_accept;
    logic                                aw_hs;
    logic                                ar_hs;
    logic [csr_pkg::axil_data_width-1:0] count_q;
    logic [csr_pkg::axil_data_width-1:0] rd_mux;

    function automatic logic addr_mapped(input logic [csr_pkg::axil_addr_width-1:0] a);
        return (a == csr_pkg::ctrl_addr) || (a == csr_pkg::status_addr)
               || (a == csr_pkg::count_addr);
    endfunction

    assign awready = wr_accept;
    assign wready  = wr_accept;
    assign arready = rd_accept;
    assign aw_hs   = wr_accept && awvalid && wvalid;
    assign ar_hs   = rd_accept && arvalid;

    // ----------------------------------------
    // read mux
    // ----------------------------------------
    always_comb begin
        rd_mux = '0;
        case (araddr)
            csr_pkg::ctrl_addr: begin
                rd_mux[csr_pkg::ctrl_enable_bit] = ctrl.issue_enable;  // flush reads 0
            end
            csr_pkg::status_addr: begin
                rd_mux[3:0]                       = ctrl.occupancy;
                rd_mux[csr_pkg::status_full_bit]  = (ctrl.occupancy == iq_pkg::iq_depth);
                rd_mux[csr_pkg::status_empty_bit] = (ctrl.occupancy == '0);
            end
            csr_pkg::count_addr: rd_mux = count_q;
            default:             rd_mux = '0;
        endcase
    end

    // ----------------------------------------
    // channel control and registers
    // ----------------------------------------
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            wr_accept         <= 1'b0;
            rd_accept         <= 1'b0;
            bvalid            <= 1'b0;
            rvalid            <= 1'b0;
            ctrl.issue_enable <= 1'b0;
            ctrl.flush        <= 1'b0;
            count_q           <= '0;
        end else begin
            // ready only while idle, one cycle at a time
            wr_accept <= awvalid && wvalid && !wr_accept && !bvalid;
            rd_accept <= arvalid && !rd_accept && !rvalid;

            if (aw_hs)       bvalid <= 1'b1;
            else if (bready) bvalid <= 1'b0;
            if (ar_hs)       rvalid <= 1'b1;
            else if (rready) rvalid <= 1'b0;

            ctrl.flush <= 1'b0;     // default low, pulse below
            if (aw_hs && (awaddr == csr_pkg::ctrl_addr) && wstrb[0]) begin
                ctrl.issue_enable <= wdata[csr_pkg::ctrl_enable_bit];
                ctrl.flush        <= wdata[csr_pkg::ctrl_flush_bit];
            end

            if (aw_hs && (awaddr == csr_pkg::count_addr)) begin
                count_q <= '0;      // any value clears
            end else if (ctrl.issue_fire) begin
                count_q <= count_q + 1'b1;
            end
        end
    end

    // response payload
    always_ff @(posedge clock) begin
        if (aw_hs) begin
            bresp <= addr_mapped(awaddr) ? csr_pkg::resp_okay : csr_pkg::resp_slverr;
        end
        if (ar_hs) begin
            rdata <= rd_mux;
            rresp <= addr_mapped(araddr) ? csr_pkg::resp_okay : csr_pkg::resp_slverr;
        end
    end

endmodule

// ==== rtl/iq_ctrl_if.sv ====
interface iq_ctrl_if;

    // from the register block
    logic       issue_enable;
    logic       flush;          // one cycle pulse

    // from the queue
    logic [3:0] occupancy;
    logic       issue_fire;     // one cycle per issued instr

    modport csr (
        output issue_enable,
        output flush,
        input  occupancy,
        input  issue_fire
    );

    modport queue (
        input  issue_enable,
        input  flush,
        output occupancy,
        output issue_fire
    );

endinterface

// ==== rtl/iq_entry_array.sv ====
module iq_entry_array (
    input  logic                         clock,
    input  logic                         reset_n,
    input  logic                         enq_valid,
    output logic                         enq_ready,
    input  iq_pkg::iq_entry_t            enq_entry,
    input  logic                         wakeup_valid,
    input  logic [iq_pkg::tag_width-1:0] wakeup_tag,
    output logic                         issue_valid,
    input  logic                         issue_ready,
    output iq_pkg::iq_entry_t            issue_entry,
    iq_age_if.array                      age,
    iq_ctrl_if.queue                     ctrl
);

    iq_pkg::iq_entry_t           entries_q [iq_pkg::iq_depth];   // payload, no reset
    logic [iq_pkg::iq_depth-1:0] valid_q;
    logic [iq_pkg::iq_depth-1:0] free_oh;
    logic [iq_pkg::iq_log:0]     occ_q;     // 0 to iq_depth
    logic                        enq_fire;
    logic                        issue_fire;

    // mark sources produced by this cycle's broadcast
    function automatic iq_pkg::iq_entry_t apply_wakeup(input iq_pkg::iq_entry_t e);
        iq_pkg::iq_entry_t r;
        r = e;
        if (wakeup_valid && (e.src1_tag == wakeup_tag)) begin
            r.src1_rdy = 1'b1;
        end
        if (wakeup_valid && (e.src2_tag == wakeup_tag)) begin
            r.src2_rdy = 1'b1;
        end
        return r;
    endfunction

    // ----------------------------------------
    // allocation and handshakes
    // ----------------------------------------
    assign free_oh     = ~valid_q & (valid_q + 1'b1);  // lowest zero bit
    assign enq_ready   = (occ_q < iq_pkg::iq_depth) && !ctrl.flush;
    assign enq_fire    = enq_valid && enq_ready;
    assign issue_valid = ctrl.issue_enable && age.oldest_found;
    assign issue_fire  = issue_valid && issue_ready;

    assign age.wren_oh  = enq_fire ? free_oh : '0;
    assign age.valid    = valid_q;
    assign age.clear_oh = ctrl.flush ? '1 : (issue_fire ? age.oldest_oh : '0);

    assign ctrl.issue_fire = issue_fire;
    assign ctrl.occupancy  = occ_q;

    // ready vector and issue mux
    always_comb begin
        issue_entry = '0;
        for (int i = 0; i < iq_pkg::iq_depth; i++) begin
            age.ready_to_go[i] = valid_q[i] && entries_q[i].src1_rdy
                                 && entries_q[i].src2_rdy;
            if (age.oldest_oh[i]) begin
                issue_entry = entries_q[i];    // one hot select
            end
        end
    end

    // ----------------------------------------
    // state
    // ----------------------------------------
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            valid_q <= '0;
            occ_q   <= '0;
        end else if (ctrl.flush) begin
            valid_q <= '0;      // drop everything
            occ_q   <= '0;
        end else begin
            valid_q <= (valid_q & ~age.clear_oh) | age.wren_oh;
            case ({enq_fire, issue_fire})
                2'b10:   occ_q <= occ_q + 1'b1;
                2'b01:   occ_q <= occ_q - 1'b1;
                default: occ_q <= occ_q;    // none or both
            endcase
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < iq_pkg::iq_depth; i++) begin
            if (age.wren_oh[i]) begin
                entries_q[i] <= apply_wakeup(enq_entry);    // same cycle wakeup counts
            end else begin
                entries_q[i] <= apply_wakeup(entries_q[i]);
            end
        end
    end

endmodule

// ==== rtl/iq_pkg.sv ====
package iq_pkg;

    // ----------------------------------------
    // queue geometry
    // ----------------------------------------
    localparam int iq_depth  = 8;
    localparam int iq_log    = 3;   // entry index width
    localparam int tag_width = 6;   // physical register tag

    // ----------------------------------------
    // opcodes
    // ----------------------------------------
    typedef enum logic [3:0] {
        alu_add = 4'h0,
        alu_sub = 4'h1,
        alu_and = 4'h2,
        alu_or  = 4'h3,
        mul     = 4'h4,
        load    = 4'h5,
        store   = 4'h6,
        branch  = 4'h7
    } opcode_e;

    // one queue slot, tags only
    typedef struct packed {
        opcode_e                opcode;
        logic [tag_width-1:0]   dst_tag;
        logic [tag_width-1:0]   src1_tag;
        logic                   src1_rdy;   // operand produced
        logic [tag_width-1:0]   src2_tag;
        logic                   src2_rdy;
    } iq_entry_t;

endpackage

// ==== rtl/issue_queue_top.sv ====
module issue_queue_top (
    input  logic                                   clock,
    input  logic                                   reset_n,
    // axi4-lite slave
    input  logic [csr_pkg::axil_addr_width-1:0]    awaddr,
    input  logic                                   awvalid,
    output logic                                   awready,
    input  logic [csr_pkg::axil_data_width-1:0]    wdata,
    input  logic [csr_pkg::axil_data_width/8-1:0]  wstrb,
    input  logic                                   wvalid,
    output logic                                   wready,
    output logic [1:0]                             bresp,
    output logic                                   bvalid,
    input  logic                                   bready,
    input  logic [csr_pkg::axil_addr_width-1:0]    araddr,
    input  logic                                   arvalid,
    output logic                                   arready,
    output logic [csr_pkg::axil_data_width-1:0]    rdata,
    output logic [1:0]                             rresp,
    output logic                                   rvalid,
    input  logic                                   rready,
    // enqueue
    input  logic                                   enq_valid,
    output logic                                   enq_ready,
    input  iq_pkg::iq_entry_t                      enq_entry,
    // result broadcast
    input  logic                                   wakeup_valid,
    input  logic [iq_pkg::tag_width-1:0]           wakeup_tag,
    // issue
    output logic                                   issue_valid,
    input  logic                                   issue_ready,
    output iq_pkg::opcode_e                        issue_opcode,
    output logic [iq_pkg::tag_width-1:0]           issue_dst_tag,
    output logic [iq_pkg::tag_width-1:0]           issue_src1_tag,
    output logic [iq_pkg::tag_width-1:0]           issue_src2_tag
);

    iq_pkg::iq_entry_t issue_entry;

    iq_age_if #(.depth(iq_pkg::iq_depth)) age_if ();
    iq_ctrl_if                            ctrl_if ();

    iq_entry_array u_iq_entry_array (
        .clock        (clock),
        .reset_n      (reset_n),
        .enq_valid    (enq_valid),
        .enq_ready    (enq_ready),
        .enq_entry    (enq_entry),
        .wakeup_valid (wakeup_valid),
        .wakeup_tag   (wakeup_tag),
        .issue_valid  (issue_valid),
        .issue_ready  (issue_ready),
        .issue_entry  (issue_entry),
        .age          (age_if.array),
        .ctrl         (ctrl_if.queue)
    );

    age_deq_policy u_age_deq_policy (
        .clock   (clock),
        .reset_n (reset_n),
        .age     (age_if.policy)
    );

    iq_csr u_iq_csr (
        .clock   (clock),
        .reset_n (reset_n),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .ctrl    (ctrl_if.csr)
    );

    // ready bits stay inside the queue
    assign issue_opcode   = issue_entry.opcode;
    assign issue_dst_tag  = issue_entry.dst_tag;
    assign issue_src1_tag = issue_entry.src1_tag;
    assign issue_src2_tag = issue_entry.src2_tag;

endmodule

// ==== tb/iq_tb_tasks.svh ====
// ----------------------------------------
// checks and waits
// ----------------------------------------
task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        $display("Mismatch %s: got %h expected %h", name, got, exp);
        errors++;
    end
endtask

task automatic note_timeout(input logic arrived, input string what);
    if (!arrived) begin
        $display("timed out waiting for %s", what);
        errors++;
    end
endtask

// next edge, then on to the drive point
task automatic tick();
    @(posedge clock);
    #5;
endtask

task automatic wait_pending(input int target, input int limit);
    int n;
    n = 0;
    while (model_q.size() != target && n < limit) begin
        tick();
        n++;
    end
    note_timeout(model_q.size() == target, "pending entries to reach the expected count");
endtask

// issue_valid must stay low over the window
task automatic watch_idle(input int cycles);
    logic seen;
    seen = 1'b0;
    for (int n = 0; n < cycles; n++) begin
        seen |= issue_valid;
        tick();
    end
    check("issue_valid", seen, 1'b0);
endtask

// ----------------------------------------
// axi4-lite master
// ----------------------------------------
task automatic axil_write(input logic [csr_pkg::axil_addr_width-1:0] addr,
                          input logic [csr_pkg::axil_data_width-1:0] data);
    int n;
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = 1'b1;
    n = 0;
    do begin
        @(posedge clock);   // ready seen at edge = accepted
        n++;
    end while (!awready && n < 50);
    note_timeout(awready, "awready");
    check("wready", wready, 1'b1);      // w taken in the same beat as aw
    #5;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    n = 0;
    do begin
        @(posedge clock);
        n++;
    end while (!bvalid && n < 50);
    note_timeout(bvalid, "bvalid");
    check("bresp", bresp, csr_pkg::resp_okay);    // only mapped writes here
    #5;
    bready = 1'b0;
endtask

task automatic axil_read(input logic [csr_pkg::axil_addr_width-1:0] addr,
                         output logic [csr_pkg::axil_data_width-1:0] data,
                         output logic [1:0] resp);
    int n;
    araddr  = addr;     // held until the next read
    arvalid = 1'b1;
    rready  = 1'b1;
    n = 0;
    do begin
        @(posedge clock);
        n++;
    end while (!arready && n < 50);
    note_timeout(arready, "arready");
    #5;
    arvalid = 1'b0;
    n = 0;
    do begin
        @(posedge clock);
        n++;
    end while (!rvalid && n < 50);
    note_timeout(rvalid, "rvalid");
    data = rdata;
    resp = rresp;
    #5;
    rready = 1'b0;
endtask

task automatic read_expect(input logic [csr_pkg::axil_addr_width-1:0] addr,
                           input logic [31:0] exp, input string name);
    logic [31:0] data;
    logic [1:0]  resp;
    axil_read(addr, data, resp);
    check(name, data, exp);
    check("rresp", resp, csr_pkg::resp_okay);
endtask

// ----------------------------------------
// queue side
// ----------------------------------------
task automatic enqueue(input iq_pkg::iq_entry_t e);
    int n;
    enq_entry = e;
    enq_valid = 1'b1;
    n = 0;
    do begin
        @(posedge clock);   // full queue backs off
        n++;
    end while (!enq_ready && n < 200);
    note_timeout(enq_ready, "enq_ready");
    #5;
    enq_valid = 1'b0;
endtask

task automatic broadcast(input logic [iq_pkg::tag_width-1:0] tag);
    wakeup_valid = 1'b1;
    wakeup_tag   = tag;
    tick();
    wakeup_valid = 1'b0;
endtask

task automatic report_test(input string name, input int errs_before);
    if (errors == errs_before) begin
        $display("%s: ok", name);
        tests_passed++;
    end else begin
        $display("%s: failed with %0d errors", name, errors - errs_before);
        tests_failed++;
    end
endtask

// ==== tb/issue_queue_tb.sv ====
module issue_queue_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic                                   clock;
    logic                                   reset_n;
    logic [csr_pkg::axil_addr_width-1:0]    awaddr;
    logic                                   awvalid;
    logic                                   awready;
    logic [csr_pkg::axil_data_width-1:0]    wdata;
    logic [csr_pkg::axil_data_width/8-1:0]  wstrb;
    logic                                   wvalid;
    logic                                   wready;
    logic [1:0]                             bresp;
    logic                                   bvalid;
    logic                                   bready;
    logic [csr_pkg::axil_addr_width-1:0]    araddr;
    logic                                   arvalid;
    logic                                   arready;
    logic [csr_pkg::axil_data_width-1:0]    rdata;
    logic [1:0]                             rresp;
    logic                                   rvalid;
    logic                                   rready;
    logic                                   enq_valid;
    logic                                   enq_ready;
    iq_pkg::iq_entry_t                      enq_entry;
    logic                                   wakeup_valid;
    logic [iq_pkg::tag_width-1:0]           wakeup_tag;
    logic                                   issue_valid;
    logic                                   issue_ready;
    iq_pkg::opcode_e                        issue_opcode;
    logic [iq_pkg::tag_width-1:0]           issue_dst_tag;
    logic [iq_pkg::tag_width-1:0]           issue_src1_tag;
    logic [iq_pkg::tag_width-1:0]           issue_src2_tag;

    // ----------------------------------------
    // model and bookkeeping
    // ----------------------------------------
    iq_pkg::iq_entry_t model_q [$];     // pending, oldest first
    iq_pkg::iq_entry_t batch [20];      // random batch of test 3
    int                seed = 32'hd220;
    int                errors = 0;
    int                tests_passed = 0;
    int                tests_failed = 0;
    int                fire_count = 0;  // issue fires seen
    logic              enq_done;

    `include "iq_tb_tasks.svh"

    issue_queue_top u_issue_queue_top (.*);

    always #50 clock = ~clock;

    // first pending entry with both sources ready, -1 when none
    function automatic int oldest_ready_index();
        foreach (model_q[k]) begin
            if (model_q[k].src1_rdy && model_q[k].src2_rdy) begin
                return k;
            end
        end
        return -1;
    endfunction

    function automatic iq_pkg::iq_entry_t build_entry(input iq_pkg::opcode_e op,
            input logic [5:0] dst, input logic [5:0] s1, input logic r1,
            input logic [5:0] s2, input logic r2);
        return '{opcode: op, dst_tag: dst, src1_tag: s1, src1_rdy: r1,
                 src2_tag: s2, src2_rdy: r2};
    endfunction

    // ----------------------------------------
    // compare process, pre-edge state
    // ----------------------------------------
    always @(posedge clock) begin
        int                idx;
        iq_pkg::iq_entry_t e;
        if (reset_n) begin
            if (issue_valid && issue_ready) begin
                idx = oldest_ready_index();
                if (idx < 0) begin
                    $display("issue fired while no pending entry was ready");
                    errors++;
                end else begin
                    check("issue_dst_tag", issue_dst_tag, model_q[idx].dst_tag);
                    check("issue_opcode", issue_opcode, model_q[idx].opcode);
                    check("issue_src1_tag", issue_src1_tag, model_q[idx].src1_tag);
                    check("issue_src2_tag", issue_src2_tag, model_q[idx].src2_tag);
                    model_q.delete(idx);
                end
                fire_count++;
            end
            if (enq_valid && enq_ready) begin
                model_q.push_back(enq_entry);   // ahead of wakeup, same cycle match
            end
            if (wakeup_valid) begin
                foreach (model_q[k]) begin
                    e = model_q[k];
                    e.src1_rdy |= (e.src1_tag == wakeup_tag);
                    e.src2_rdy |= (e.src2_tag == wakeup_tag);
                    model_q[k] = e;
                end
            end
        end
    end

    initial begin
        logic [31:0] rd;
        logic [1:0]  resp;
        int          mark;
        logic [3:0]  t1;
        logic [3:0]  t2;
        clock        = 1'b0;
        reset_n      = 1'b0;
        awaddr       = '0;
        awvalid      = 1'b0;
        wdata        = '0;
        wstrb        = '1;      // full words only
        wvalid       = 1'b0;
        bready       = 1'b0;
        araddr       = '0;
        arvalid      = 1'b0;
        rready       = 1'b0;
        enq_valid    = 1'b0;
        enq_entry    = '0;
        wakeup_valid = 1'b0;
        wakeup_tag   = '0;
        issue_ready  = 1'b0;
        enq_done     = 1'b0;
        repeat (16) @(posedge clock);
        #5;
        reset_n = 1'b1;

        // reset values and register access
        mark = errors;
        check("issue_valid", issue_valid, 1'b0);
        check("enq_ready", enq_ready, 1'b1);
        read_expect(csr_pkg::ctrl_addr, 32'h0, "ctrl");
        read_expect(csr_pkg::status_addr, 32'h20, "status");   // empty, occupancy 0
        read_expect(csr_pkg::count_addr, 32'h0, "count");
        axil_read(4'hc, rd, resp);                             // unmapped
        check("rresp", resp, csr_pkg::resp_slverr);
        axil_write(csr_pkg::ctrl_addr, 32'h1);
        read_expect(csr_pkg::ctrl_addr, 32'h1, "ctrl");
        report_test("reset and registers", mark);

        // fill while stalled, then drain
        mark = errors;
        for (int i = 0; i < 8; i++) begin
            enqueue(build_entry(iq_pkg::opcode_e'(4'(i)), 6'(i + 8), 6'(i), 1'b1,
                                6'(i + 1), 1'b1));
        end
        check("enq_ready", enq_ready, 1'b0);
        read_expect(csr_pkg::status_addr, 32'h18, "status");   // full, occupancy 8
        issue_ready = 1'b1;
        wait_pending(0, 100);
        report_test("fill and in-order drain", mark);

        // unready sources, random wakeups
        mark = errors;
        for (int i = 0; i < 20; i++) begin
            t1 = $random(seed);
            t2 = $random(seed);
            batch[i] = build_entry(iq_pkg::opcode_e'(4'(i % 8)), 6'(i + 16), {2'b0, t1}, 1'b0,
                                   {2'b0, t2}, 1'b0);
        end
        fork
            begin
                foreach (batch[i]) begin
                    enqueue(batch[i]);
                end
                enq_done = 1'b1;
            end
            begin
                for (int n = 0; n < 2000 && !(enq_done && model_q.size() == 0); n++) begin
                    t1 = $random(seed);
                    wakeup_valid = 1'b1;
                    wakeup_tag   = {2'b0, t1};  // small tag space, hits often
                    tick();
                end
                wakeup_valid = 1'b0;
            end
        join
        note_timeout(model_q.size() == 0, "the random batch to drain");
        report_test("random wakeup order", mark);

        // wakeup in the consumer's enqueue cycle
        mark = errors;
        enqueue(build_entry(iq_pkg::mul, 6'd50, 6'd40, 1'b0, 6'd1, 1'b1));    // older, blocked
        wakeup_valid = 1'b1;
        wakeup_tag   = 6'd41;
        enqueue(build_entry(iq_pkg::load, 6'd51, 6'd41, 1'b0, 6'd2, 1'b1));
        wakeup_valid = 1'b0;
        wait_pending(1, 20);        // younger one goes first
        broadcast(6'd40);
        wait_pending(0, 20);
        report_test("same cycle wakeup", mark);

        // flush, then issue count
        mark = errors;
        issue_ready = 1'b0;
        for (int i = 0; i < 3; i++) begin
            enqueue(build_entry(iq_pkg::alu_add, 6'(i + 20), 6'd3, 1'b1, 6'd4, 1'b1));
        end
        axil_write(csr_pkg::ctrl_addr, 32'h3);     // enable kept, flush pulse
        model_q.delete();
        read_expect(csr_pkg::status_addr, 32'h20, "status");
        issue_ready = 1'b1;
        watch_idle(20);
        read_expect(csr_pkg::count_addr, fire_count, "count");
        axil_write(csr_pkg::count_addr, 32'h5a);
        read_expect(csr_pkg::count_addr, 32'h0, "count");
        fire_count = 0;
        report_test("flush and issue count", mark);

        // issue held off by issue_enable
        mark = errors;
        axil_write(csr_pkg::ctrl_addr, 32'h0);
        for (int i = 0; i < 4; i++) begin
            enqueue(build_entry(iq_pkg::branch, 6'(i + 30), 6'(i), 1'b1, 6'(i + 5), 1'b1));
        end
        watch_idle(30);
        axil_write(csr_pkg::ctrl_addr, 32'h1);
        wait_pending(0, 50);
        report_test("issue enable gating", mark);

        $display("tests passed %0d failed %0d", tests_passed, tests_failed);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
